// File: source/bus_pkg.sv
// System bus types
package bus_pkg;

  // ==============================
  // data beat geometry
  // ==============================
  localparam int LANES  = 8;               // 16-bit lanes per beat
  localparam int LANE_W = 16;              // bits per lane
  localparam int DAT_W  = LANES * LANE_W;  // full 128-bit beat
  localparam int SEL_W  = 2 * LANES;       // byte selects, two per lane
  localparam int ADR_W  = 32;

  // ==============================
  // slave port request
  // ==============================
  // one request as sampled from the bus
  typedef struct packed {
    logic             cyc;  // bus cycle in progress
    logic             stb;  // strobe
    logic             we;   // write when set
    logic [SEL_W-1:0] sel;  // byte selects
    logic [ADR_W-1:0] adr;  // byte address
    logic [DAT_W-1:0] dat;  // write data
  } bus_req_t;

endpackage

// File: source/xbus_pkg.sv
// Link word types
package xbus_pkg;

  // ==============================
  // link word format
  // ==============================
  localparam int OP_W  = 4;   // opcode field
  localparam int PAY_W = 20;  // payload field, 24-bit word in total

  // opcodes, data opcodes take the upper half so bit 3 marks data
  typedef enum logic [OP_W-1:0] {
    OP_NOP     = 4'd0,   // filler, no meaning
    OP_ADDR_LO = 4'd1,   // address bits 19..0
    OP_ADDR_HI = 4'd2,   // address bits 31..20 in payload 11..0
    OP_CTRL    = 4'd3,   // we, done and select mask
    OP_DATA0   = 4'd8,   // lane 0, bits 15..0
    OP_DATA1   = 4'd9,
    OP_DATA2   = 4'd10,
    OP_DATA3   = 4'd11,
    OP_DATA4   = 4'd12,
    OP_DATA5   = 4'd13,
    OP_DATA6   = 4'd14,
    OP_DATA7   = 4'd15   // lane 7, bits 127..112
  } xbus_op_e;

  typedef struct packed {
    xbus_op_e         op;
    logic [PAY_W-1:0] payload;
  } xbus_word_t;

  // ==============================
  // control word payload layout
  // ==============================
  localparam int CTRL_WE_BIT   = 19;  // request is a write
  localparam int CTRL_DONE_BIT = 18;  // completion marker
  localparam int CTRL_SEL_LSB  = 0;   // select mask position
  localparam int CTRL_SEL_W    = 16;  // select mask width

  localparam int ADDR_LO_W = 20;      // address bits carried by OP_ADDR_LO

  // idle word, also the reset value of the link
  localparam xbus_word_t XBUS_NOP = '{op: OP_NOP, payload: '0};

endpackage

// File: source/xbus_frame_gen.sv
// Link frame timing generator
module xbus_frame_gen #(
  parameter int H_TOTAL  = 1056,  // clocks per line
  parameter int H_ACTIVE = 800,   // active clocks per line
  parameter int H_SYNC   = 128,   // hsync width after active region
  parameter int V_TOTAL  = 628,   // lines per frame
  parameter int V_ACTIVE = 600,   // active lines per frame
  parameter int V_SYNC   = 4      // vsync width in lines
) (
  input  logic clk_i,
  input  logic rst_i,
  output logic de_o,     // data enable
  output logic hsync_o,
  output logic vsync_o
);

  localparam int HW = $clog2(H_TOTAL);
  localparam int VW = $clog2(V_TOTAL);

  logic [HW-1:0] h_q;    // pixel within line
  logic [VW-1:0] v_q;    // line within frame
  logic          h_last;
  logic          v_last;
  logic          h_act;
  logic          v_act;
  logic          h_sync;
  logic          v_sync;

  // ==============================
  // region decode
  // ==============================
  assign h_last = (int'(h_q) == H_TOTAL - 1);
  assign v_last = (int'(v_q) == V_TOTAL - 1);
  assign h_act  = (int'(h_q) < H_ACTIVE);
  assign v_act  = (int'(v_q) < V_ACTIVE);
  // syncs start right where the active region ends
  assign h_sync = (int'(h_q) >= H_ACTIVE) && (int'(h_q) < H_ACTIVE + H_SYNC);
  assign v_sync = (int'(v_q) >= V_ACTIVE) && (int'(v_q) < V_ACTIVE + V_SYNC);

  // ==============================
  // counters
  // ==============================
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      h_q <= '0;
      v_q <= '0;
    end
    else if (h_last)
    begin
      h_q <= '0;                          // wrap line
      v_q <= v_last ? '0 : v_q + 1'b1;    // next line, wrap frame
    end
    else
      h_q <= h_q + 1'b1;
  end

  // outputs one cycle behind the counters
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      de_o    <= 1'b0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
    end
    else
    begin
      de_o    <= h_act && v_act;  // both counters active
      hsync_o <= h_sync;
      vsync_o <= v_sync;
    end
  end

endmodule

// File: source/xbus_tx.sv
// Link transmit sequencer
module xbus_tx (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  bus_pkg::bus_req_t    req_i,       // registered bus request
  input  logic                 sel_hit_i,   // request is in the bridge window
  input  logic                 de_i,        // link word slot
  output xbus_pkg::xbus_word_t xbd_o,
  output logic                 wr_ack_o,
  output logic                 rd_start_o   // read completion sent
);

  typedef enum logic [2:0] {IDLE, ADDR_HI, CTRL, DATA, DONE, HOLD} tx_state_e;

  tx_state_e            state_q;
  logic [2:0]           lane_q;      // lane to send in DATA
  logic [3:0]           srch_from;   // first lane to search, 8 means none left
  logic                 srch_hit;
  logic [2:0]           srch_lane;
  xbus_pkg::xbus_word_t ctrl_word;
  xbus_pkg::xbus_word_t done_word;

  // ==============================
  // lane search
  // ==============================
  // lowest lane at or above srch_from with any byte select set
  always_comb
  begin
    srch_from = (state_q == DATA) ? {1'b0, lane_q} + 4'd1 : 4'd0;
    srch_hit  = 1'b0;
    srch_lane = '0;
    for (int k = bus_pkg::LANES - 1; k >= 0; k--)
    begin
      if ((k >= int'(srch_from)) && (req_i.sel[2*k +: 2] != 2'b00))
      begin
        srch_hit  = 1'b1;
        srch_lane = 3'(k);  // descending loop leaves the lowest hit
      end
    end
  end

  // control and completion words differ only in the done bit
  always_comb
  begin
    ctrl_word    = xbus_pkg::XBUS_NOP;
    ctrl_word.op = xbus_pkg::OP_CTRL;
    ctrl_word.payload[xbus_pkg::CTRL_WE_BIT] = req_i.we;
    ctrl_word.payload[xbus_pkg::CTRL_SEL_LSB +: xbus_pkg::CTRL_SEL_W] = req_i.sel;
    done_word = ctrl_word;
    done_word.payload[xbus_pkg::CTRL_DONE_BIT] = 1'b1;
  end

  // ==============================
  // sequencer
  // ==============================
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q    <= IDLE;
      lane_q     <= '0;
      xbd_o      <= xbus_pkg::XBUS_NOP;
      wr_ack_o   <= 1'b0;
      rd_start_o <= 1'b0;
    end
    else
    begin
      rd_start_o <= 1'b0;  // one cycle only
      case (state_q)
        IDLE:
          if (de_i)
          begin
            xbd_o <= xbus_pkg::XBUS_NOP;
            if (sel_hit_i)
            begin
              xbd_o.op      <= xbus_pkg::OP_ADDR_LO;
              xbd_o.payload <= req_i.adr[xbus_pkg::ADDR_LO_W-1:0];
              state_q       <= ADDR_HI;
            end
          end
        ADDR_HI:
          if (de_i)
          begin
            xbd_o.op      <= xbus_pkg::OP_ADDR_HI;
            xbd_o.payload <= {8'h00, req_i.adr[31:20]};  // top 12 address bits
            state_q       <= CTRL;
          end
        CTRL:
          if (de_i)
          begin
            xbd_o  <= ctrl_word;
            lane_q <= srch_lane;
            // reads and empty writes go straight to completion
            state_q <= (req_i.we && srch_hit) ? DATA : DONE;
          end
        DATA:
          if (de_i)
          begin
            xbd_o.op      <= xbus_pkg::xbus_op_e'({1'b1, lane_q});  // OP_DATA0 + lane
            xbd_o.payload <= {4'h0, req_i.dat[bus_pkg::LANE_W*lane_q +: bus_pkg::LANE_W]};
            lane_q        <= srch_lane;
            if (!srch_hit)
              state_q <= DONE;  // last selected lane sent
          end
        DONE:
          if (de_i)
          begin
            xbd_o      <= done_word;
            wr_ack_o   <= req_i.we;   // write ends here
            rd_start_o <= !req_i.we;  // read hands over to the receiver
            state_q    <= HOLD;
          end
        HOLD:
        begin
          if (de_i)
            xbd_o <= xbus_pkg::XBUS_NOP;
          // leaving sends no word, so no de slot is needed
          if (!req_i.cyc)
          begin
            wr_ack_o <= 1'b0;
            state_q  <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: source/xbus_rx.sv
// Link receive collector
module xbus_rx #(
  parameter int RD_TIMEOUT = 256  // cycles allowed for a read completion
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      rd_start_i,  // arm for one read
  input  logic                      cyc_i,
  input  xbus_pkg::xbus_word_t      xbd_i,       // words from the far end
  output logic [bus_pkg::DAT_W-1:0] dat_o,
  output logic                      rd_ack_o,
  output logic                      berr_o
);

  localparam int TW = $clog2(RD_TIMEOUT + 1);

  typedef enum logic [1:0] {IDLE, COLLECT, HOLD} rx_state_e;

  rx_state_e     state_q;
  logic [TW-1:0] tmo_q;     // cycles spent collecting
  logic          tmo_hit;
  logic          is_data;
  logic          is_done;
  logic [2:0]    rx_lane;

  // ==============================
  // word decode
  // ==============================
  assign is_data = (xbd_i.op >= xbus_pkg::OP_DATA0);  // upper opcode half
  assign is_done = (xbd_i.op == xbus_pkg::OP_CTRL) && xbd_i.payload[xbus_pkg::CTRL_DONE_BIT];
  assign rx_lane = xbd_i.op[2:0];                     // lane from data opcode
  assign tmo_hit = (int'(tmo_q) == RD_TIMEOUT - 1);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q  <= IDLE;
      tmo_q    <= '0;
      dat_o    <= '0;
      rd_ack_o <= 1'b0;
      berr_o   <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (rd_start_i)
          begin
            dat_o   <= '0;  // unselected lanes read back as zero
            tmo_q   <= '0;
            state_q <= COLLECT;
          end
        COLLECT:
        begin
          tmo_q <= tmo_q + 1'b1;
          if (is_data)
            dat_o[bus_pkg::LANE_W*rx_lane +: bus_pkg::LANE_W] <=
              xbd_i.payload[bus_pkg::LANE_W-1:0];
          // completion wins over a timeout in the same cycle
          if (is_done)
          begin
            rd_ack_o <= 1'b1;
            state_q  <= HOLD;
          end
          else if (tmo_hit)
          begin
            berr_o  <= 1'b1;  // far end never completed
            state_q <= HOLD;
          end
        end
        HOLD:
          if (!cyc_i)  // master has ended the cycle
          begin
            rd_ack_o <= 1'b0;
            berr_o   <= 1'b0;
            state_q  <= IDLE;
          end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: source/xbus_bridge.sv
// System bus to link bridge
module xbus_bridge #(
  parameter logic [7:0] BRIDGE_BASE = 8'hFB,  // address bits 31..24 of the window
  parameter int H_TOTAL    = 1056,
  parameter int H_ACTIVE   = 800,
  parameter int H_SYNC     = 128,
  parameter int V_TOTAL    = 628,
  parameter int V_ACTIVE   = 600,
  parameter int V_SYNC     = 4,
  parameter int RD_TIMEOUT = 256
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [bus_pkg::SEL_W-1:0] sel_i,
  input  logic [bus_pkg::ADR_W-1:0] adr_i,
  input  logic [bus_pkg::DAT_W-1:0] dat_i,
  output logic [bus_pkg::DAT_W-1:0] dat_o,
  output logic                      ack_o,
  output logic                      berr_o,
  output xbus_pkg::xbus_word_t      xbd_o,
  input  xbus_pkg::xbus_word_t      xbd_i,
  output logic                      xb_de_o,
  output logic                      xb_hsync_o,
  output logic                      xb_vsync_o
);

  bus_pkg::bus_req_t req_d;
  bus_pkg::bus_req_t req_q;     // request, one cycle behind the bus
  logic              sel_hit;   // registered request hits the window
  logic              de;
  logic              hsync;
  logic              vsync;
  logic              wr_ack;
  logic              rd_ack;
  logic              rd_start;

  // ==============================
  // request register and decode
  // ==============================
  assign req_d = '{cyc: cyc_i, stb: stb_i, we: we_i, sel: sel_i, adr: adr_i, dat: dat_i};

  always_ff @(posedge clk_i)
  begin
    req_q <= req_d;
    if (rst_i)
    begin
      req_q.cyc <= 1'b0;  // no cycle out of reset
      req_q.stb <= 1'b0;
    end
  end

  assign sel_hit = req_q.cyc && req_q.stb && (req_q.adr[bus_pkg::ADR_W-1 -: 8] == BRIDGE_BASE);

  // de is delayed so xb_de_o lines up with the word tx loads on de
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      xb_de_o    <= 1'b0;
      xb_hsync_o <= 1'b0;
      xb_vsync_o <= 1'b0;
    end
    else
    begin
      xb_de_o    <= de;
      xb_hsync_o <= hsync;
      xb_vsync_o <= vsync;
    end
  end

  assign ack_o = wr_ack | rd_ack;  // writes end in tx, reads in rx

  // ==============================
  // blocks
  // ==============================
  xbus_frame_gen #(
    .H_TOTAL (H_TOTAL),
    .H_ACTIVE(H_ACTIVE),
    .H_SYNC  (H_SYNC),
    .V_TOTAL (V_TOTAL),
    .V_ACTIVE(V_ACTIVE),
    .V_SYNC  (V_SYNC)
  ) i_xbus_frame_gen (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .de_o   (de),
    .hsync_o(hsync),
    .vsync_o(vsync)
  );

  xbus_tx i_xbus_tx (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (req_q),
    .sel_hit_i (sel_hit),
    .de_i      (de),
    .xbd_o     (xbd_o),
    .wr_ack_o  (wr_ack),
    .rd_start_o(rd_start)
  );

  xbus_rx #(
    .RD_TIMEOUT(RD_TIMEOUT)
  ) i_xbus_rx (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_start_i(rd_start),
    .cyc_i     (cyc_i),   // raw cyc so ack and berr drop on the next edge
    .xbd_i     (xbd_i),
    .dat_o     (dat_o),
    .rd_ack_o  (rd_ack),
    .berr_o    (berr_o)
  );

endmodule

// File: tests/xbus_far_end.sv
// Link far-end model
module xbus_far_end (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 respond_i,   // answer read completions
  input  logic                 de_i,        // link data enable
  input  xbus_pkg::xbus_word_t word_i,      // words from the bridge
  output xbus_pkg::xbus_word_t word_o,      // words back to the bridge
  output logic                 pace_err_o   // link word changed outside a de cycle
);
  timeunit 1ns;
  timeprecision 1ps;

  xbus_pkg::xbus_word_t log_q [0:255];  // every non-NOP word taken in a de cycle
  int                   log_cnt;
  logic [15:0]          mem [0:255];    // index is beat address bits 8..4 and lane
  logic [31:0]          adr_q;          // address rebuilt from the two address words
  xbus_pkg::xbus_word_t prev_q;         // word seen in the previous cycle
  xbus_pkg::xbus_word_t resp_q [$];     // return words waiting to go out

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = {8'(i) ^ 8'hA5, 8'(i)};  // unique per entry
    log_cnt    = 0;
    adr_q      = '0;
    prev_q     = xbus_pkg::XBUS_NOP;
    pace_err_o = 1'b0;
    word_o     = xbus_pkg::XBUS_NOP;
  end

  // data words for the selected lanes, then the completion
  task automatic queue_read(input logic [15:0] sel);
    xbus_pkg::xbus_word_t w;
    for (int k = 0; k < bus_pkg::LANES; k++)
    begin
      if (sel[2*k +: 2] != 2'b00)
      begin
        w.op      = xbus_pkg::xbus_op_e'(4'(8 + k));
        w.payload = {4'h0, mem[{adr_q[8:4], 3'(k)}]};
        resp_q.push_back(w);
      end
    end
    w         = xbus_pkg::XBUS_NOP;
    w.op      = xbus_pkg::OP_CTRL;
    w.payload[xbus_pkg::CTRL_DONE_BIT] = 1'b1;
    w.payload[15:0] = sel;
    resp_q.push_back(w);
  endtask

  // ==============================
  // link monitor and responder
  // ==============================
  always @(negedge clk_i)
  begin
    if (rst_i)
    begin
      word_o <= xbus_pkg::XBUS_NOP;
      prev_q = xbus_pkg::XBUS_NOP;
      resp_q.delete();
    end
    else
    begin
      // return path is not paced, one word per cycle
      if (resp_q.size() > 0)
        word_o <= resp_q.pop_front();
      else
        word_o <= xbus_pkg::XBUS_NOP;
      if ((word_i != prev_q) && !de_i)
        pace_err_o = 1'b1;  // sticky
      prev_q = word_i;
      if (de_i && (word_i.op != xbus_pkg::OP_NOP))
      begin
        if (log_cnt < 256)
          log_q[log_cnt] = word_i;
        log_cnt++;
        if (word_i.op == xbus_pkg::OP_ADDR_LO)
          adr_q[19:0] = word_i.payload;
        else if (word_i.op == xbus_pkg::OP_ADDR_HI)
          adr_q[31:20] = word_i.payload[11:0];
        else if ((word_i.op == xbus_pkg::OP_CTRL) && respond_i &&
                 word_i.payload[xbus_pkg::CTRL_DONE_BIT] &&
                 !word_i.payload[xbus_pkg::CTRL_WE_BIT])
          queue_read(word_i.payload[15:0]);  // read completion
      end
    end
  end

endmodule

// File: tests/tb_xbus_bridge.sv
// Bridge testbench
module tb_xbus_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_TOTAL    = 16;
  localparam int H_ACTIVE   = 12;
  localparam int H_SYNC     = 2;
  localparam int V_TOTAL    = 4;
  localparam int V_ACTIVE   = 3;
  localparam int V_SYNC     = 1;
  localparam int RD_TIMEOUT = 64;
  localparam logic [7:0] BASE = 8'hFB;
  localparam int ROWS       = 8;
  localparam int FRAME      = H_TOTAL * V_TOTAL;
  localparam int LIMIT      = ROWS * (4 * FRAME + RD_TIMEOUT);  // whole run
  localparam int NOWIN_WAIT = 2 * FRAME;                        // out-of-window request
  localparam logic [1:0] END_ACK  = 2'd0;
  localparam logic [1:0] END_BERR = 2'd1;
  localparam logic [1:0] END_NONE = 2'd2;

  typedef struct packed {
    logic         we;
    logic         respond;  // far end answers reads
    logic [1:0]   outcome;  // expected end of the request
    logic [15:0]  sel;
    logic [31:0]  adr;
    logic [127:0] dat;
  } row_t;

  logic                 clk;
  logic                 rst;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [15:0]          sel;
  logic [31:0]          adr;
  logic [127:0]         wdat;
  logic [127:0]         rdat;
  logic                 ack;
  logic                 berr;
  xbus_pkg::xbus_word_t tx_word;
  xbus_pkg::xbus_word_t rx_word;
  logic                 xb_de;
  logic                 xb_hsync;
  logic                 xb_vsync;
  logic                 respond;
  logic                 pace_err;
  row_t                 table_q [ROWS];
  xbus_pkg::xbus_word_t exp_q [$];     // expected link words of one row
  logic [15:0]          lfsr;
  int                   cycles = 0;
  int                   de_cnt;
  int                   hs_cnt;        // hsync cycles in the current frame
  int                   vs_cnt;        // vsync cycles in the current frame
  int                   frames;
  logic                 vs_prev;

  xbus_bridge #(
    .BRIDGE_BASE(BASE),
    .H_TOTAL    (H_TOTAL),
    .H_ACTIVE   (H_ACTIVE),
    .H_SYNC     (H_SYNC),
    .V_TOTAL    (V_TOTAL),
    .V_ACTIVE   (V_ACTIVE),
    .V_SYNC     (V_SYNC),
    .RD_TIMEOUT (RD_TIMEOUT)
  ) i_xbus_bridge (
    .clk_i(clk), .rst_i(rst), .cyc_i(cyc), .stb_i(stb), .we_i(we), .sel_i(sel),
    .adr_i(adr), .dat_i(wdat), .dat_o(rdat), .ack_o(ack), .berr_o(berr),
    .xbd_o(tx_word), .xbd_i(rx_word),
    .xb_de_o(xb_de), .xb_hsync_o(xb_hsync), .xb_vsync_o(xb_vsync)
  );

  xbus_far_end i_xbus_far_end (
    .clk_i(clk), .rst_i(rst), .respond_i(respond), .de_i(xb_de),
    .word_i(tx_word), .word_o(rx_word), .pace_err_o(pace_err)
  );

  always #5 clk = ~clk;

  // ==============================
  // helpers
  // ==============================
  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [127:0] random_beat();
    logic [127:0] v;
    v = '0;
    for (int b = 0; b < 128; b++)
    begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = {v[126:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic load_table();
    table_q[0] = '{we: 1, respond: 0, outcome: END_ACK,  sel: 16'hFFFF, adr: 32'hFB00_1230, dat: '0};
    table_q[1] = '{we: 1, respond: 0, outcome: END_ACK,  sel: 16'h0C31, adr: 32'hFB12_3450, dat: '0};
    table_q[2] = '{we: 0, respond: 1, outcome: END_ACK,  sel: 16'hFFFF, adr: 32'hFB00_0040, dat: '0};
    table_q[3] = '{we: 0, respond: 1, outcome: END_ACK,  sel: 16'h3003, adr: 32'hFBAB_C0D0, dat: '0};
    table_q[4] = '{we: 0, respond: 0, outcome: END_BERR, sel: 16'h00F0, adr: 32'hFB00_0100, dat: '0};
    table_q[5] = '{we: 1, respond: 0, outcome: END_NONE, sel: 16'hFFFF, adr: 32'hFA00_0000, dat: '0};
    table_q[6] = '{we: 0, respond: 1, outcome: END_NONE, sel: 16'hFFFF, adr: 32'h1234_5670, dat: '0};
    table_q[7] = '{we: 1, respond: 0, outcome: END_ACK,  sel: 16'h0000, adr: 32'hFBFF_FFF0, dat: '0};
    for (int r = 0; r < ROWS; r++)
      table_q[r].dat = random_beat();
  endtask

  // link words the bridge must send for one request
  task automatic build_expected(input row_t rw);
    xbus_pkg::xbus_word_t w;
    exp_q.delete();
    if (rw.adr[31:24] == BASE)
    begin
      w.op      = xbus_pkg::OP_ADDR_LO;
      w.payload = rw.adr[19:0];
      exp_q.push_back(w);
      w.op      = xbus_pkg::OP_ADDR_HI;
      w.payload = {8'h00, rw.adr[31:20]};
      exp_q.push_back(w);
      w.op      = xbus_pkg::OP_CTRL;
      w.payload = '0;
      w.payload[xbus_pkg::CTRL_WE_BIT] = rw.we;
      w.payload[15:0] = rw.sel;
      exp_q.push_back(w);
      for (int k = 0; k < bus_pkg::LANES; k++)
      begin
        if (rw.we && (rw.sel[2*k +: 2] != 2'b00))
        begin
          w.op      = xbus_pkg::xbus_op_e'(4'(8 + k));
          w.payload = {4'h0, rw.dat[16*k +: 16]};
          exp_q.push_back(w);
        end
      end
      w.op      = xbus_pkg::OP_CTRL;
      w.payload = '0;
      w.payload[xbus_pkg::CTRL_WE_BIT]   = rw.we;
      w.payload[xbus_pkg::CTRL_DONE_BIT] = 1'b1;
      w.payload[15:0] = rw.sel;
      exp_q.push_back(w);
    end
  endtask

  // selected lanes from far-end memory, zero elsewhere
  function automatic logic [127:0] expected_rdata(input row_t rw);
    logic [127:0] v;
    v = '0;
    for (int k = 0; k < bus_pkg::LANES; k++)
      if (rw.sel[2*k +: 2] != 2'b00)
        v[16*k +: 16] = i_xbus_far_end.mem[{rw.adr[8:4], 3'(k)}];
    return v;
  endfunction

  task automatic run_row(input int r);
    row_t rw;
    int   n;
    int   base;
    int   i;
    rw   = table_q[r];
    base = i_xbus_far_end.log_cnt;
    build_expected(rw);
    respond = rw.respond;
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = rw.we;
    sel     = rw.sel;
    adr     = rw.adr;
    wdat    = rw.dat;
    n       = 0;
    while (!(ack || berr) && !((rw.outcome == END_NONE) && (n == NOWIN_WAIT)))
    begin
      @(negedge clk);
      n++;
    end
    check("ack_o", 128'(ack), 128'(rw.outcome == END_ACK));
    check("berr_o", 128'(berr), 128'(rw.outcome == END_BERR));
    if ((rw.outcome == END_ACK) && !rw.we)
      check("dat_o", rdat, expected_rdata(rw));
    cyc = 1'b0;
    stb = 1'b0;
    repeat (2) @(negedge clk);  // ack and berr released
    check("ack_o", 128'(ack), 128'(0));
    check("berr_o", 128'(berr), 128'(0));
    check("xbd_o word count", 128'(i_xbus_far_end.log_cnt - base), 128'(exp_q.size()));
    for (i = 0; i < exp_q.size(); i++)
      check("xbd_o", 128'(i_xbus_far_end.log_q[base + i]), 128'(exp_q[i]));
    check("xbd_o pacing", 128'(pace_err), 128'(0));
    repeat (2) @(negedge clk);
  endtask

  // ==============================
  // frame and run monitors
  // ==============================
  always @(negedge clk)
  begin
    if (rst)
    begin
      de_cnt  = 0;
      hs_cnt  = 0;
      vs_cnt  = 0;
      frames  = 0;
      vs_prev = 1'b0;
    end
    else
    begin
      if (xb_vsync && !vs_prev)  // one frame between vsync rises
      begin
        if (frames > 0)
        begin
          check("xb_de_o per frame", 128'(de_cnt), 128'(H_ACTIVE * V_ACTIVE));
          check("xb_hsync_o per frame", 128'(hs_cnt), 128'(H_SYNC * V_TOTAL));
          check("xb_vsync_o per frame", 128'(vs_cnt), 128'(V_SYNC * H_TOTAL));
        end
        de_cnt = 0;
        hs_cnt = 0;
        vs_cnt = 0;
        frames++;
      end
      vs_prev = xb_vsync;
      // hsync lies in the blanking part of each line
      check("xb_hsync_o during xb_de_o", 128'(xb_hsync && xb_de), 128'(0));
      if (xb_de)
        de_cnt++;
      if (xb_hsync)
        hs_cnt++;
      if (xb_vsync)
        vs_cnt++;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
      stop_on_error($sformatf("timeout: run did not finish within %0d cycles", LIMIT));
  end

  initial
  begin
    clk     = 1'b0;
    rst     = 1'b1;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    sel     = '0;
    adr     = '0;
    wdat    = '0;
    respond = 1'b0;
    lfsr    = 16'd26536;
    load_table();
    repeat (4) @(negedge clk);  // four reset cycles
    rst = 1'b0;
    @(negedge clk);
    for (int r = 0; r < ROWS; r++)
      run_row(r);
    check("frames seen", 128'(frames >= 2), 128'(1));
    $display("No errors");
    $finish;
  end

endmodule

// File: verilog.f
source/bus_pkg.sv
source/xbus_pkg.sv
source/xbus_frame_gen.sv
source/xbus_tx.sv
source/xbus_rx.sv
source/xbus_bridge.sv
tests/xbus_far_end.sv
tests/tb_xbus_bridge.sv

// File: Makefile
TOP = tb_xbus_bridge

.PHONY: all lint clean

# build, run, then decide on the log contents
all:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module xbus_bridge -f verilog.f

clean:
	rm -rf obj_dir sim.log
